/* rtl/dec_pkg.sv */
// Decode unit package
// Shared widths, opcode and ALU encodings, and the packets that travel
// between fetch, decode, the load scoreboard and the trace port.

package dec_pkg;

  // ****************************************
  // constants
  // ****************************************
  localparam int NBLOAD_DEPTH = 4;                  // outstanding non-blocking loads
  localparam logic [4:0] EXC_ILLEGAL_INSN = 5'd2;   // mcause code, illegal insn

  // ****************************************
  // vector types
  // ****************************************
  typedef logic [31:0] xlen_t;                      // data / instruction word
  typedef logic [31:1] pc_t;                        // halfword aligned pc
  typedef logic [4:0]  reg_addr_t;                  // gpr index
  typedef logic [$clog2(NBLOAD_DEPTH)-1:0] nbload_tag_t;

  // major opcodes handled by this decoder
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // reg-reg alu
    OPC_OP_IMM = 7'b0010011,  // reg-imm alu
    OPC_LUI    = 7'b0110111,  // upper immediate
    OPC_LOAD   = 7'b0000011   // loads, all widths
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // ****************************************
  // packets
  // ****************************************
  typedef struct packed {
    logic  valid;   // fetch offers an insn
    xlen_t instr;
    pc_t   pc;
  } fetch_pkt_t;

  typedef struct packed {
    logic    valid;
    alu_op_e op;
    logic    use_imm;  // operand b from immed
    logic    lui;      // operand a forced to zero
  } alu_pkt_t;

  typedef struct packed {
    logic        valid;
    nbload_tag_t tag;     // scoreboard slot
    logic [11:0] offset;  // address offset
  } lsu_pkt_t;

  typedef struct packed {
    logic        valid;
    nbload_tag_t tag;
    xlen_t       data;
  } nbload_ret_t;

  typedef struct packed {
    logic        valid;
    logic        exception;
    xlen_t       insn;
    logic [31:0] address;
    logic [4:0]  ecause;
    xlen_t       tval;
  } trace_pkt_t;

endpackage

/* rtl/dec_ib.sv */
// Instruction buffer
// Single entry between fetch and decode. The held entry is the D stage;
// a fresh insn can be loaded in the same cycle decode consumes the old one.

`timescale 1ns/1ps

module dec_ib (
  input  logic               clk,
  input  logic               rst_n,
  input  dec_pkg::fetch_pkt_t fetch,
  output logic               fetch_ready,
  input  logic               decode_take,
  output dec_pkg::fetch_pkt_t ib_pkt
);

  logic           active_q;  // low through reset, then stays high
  logic           ib_vld_q;
  dec_pkg::xlen_t ib_instr_q;
  dec_pkg::pc_t   ib_pc_q;
  logic           load;

  // ready when empty or draining this cycle
  assign fetch_ready = active_q & (~ib_vld_q | decode_take);
  assign load        = fetch.valid & fetch_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active_q <= 1'b0;
      ib_vld_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (load) begin
        ib_vld_q <= 1'b1;  // refill wins over consume
      end else if (decode_take) begin
        ib_vld_q <= 1'b0;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (load) begin
      ib_instr_q <= fetch.instr;
      ib_pc_q    <= fetch.pc;
    end
  end

  always_comb begin
    ib_pkt.valid = ib_vld_q;
    ib_pkt.instr = ib_instr_q;
    ib_pkt.pc    = ib_pc_q;
  end

endmodule

/* rtl/dec_decode.sv */
// D-stage decode and pipeline control
// Decodes OP, OP-IMM, LUI and LOAD, builds the immediate and the ALU/LSU
// packets, stalls on register hazards and walks each insn through X and R.
// R drives GPR write port 0 and feeds the WB register in the trace block.

`timescale 1ns/1ps

module dec_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dec_pkg::fetch_pkt_t  ib_pkt,
  output logic                 decode_take,
  output dec_pkg::reg_addr_t   rs1_addr,
  output dec_pkg::reg_addr_t   rs2_addr,
  input  dec_pkg::xlen_t       gpr_rs1,
  input  dec_pkg::xlen_t       gpr_rs2,
  input  logic                 sb_pending_hit,
  input  logic                 sb_tag_free,
  input  dec_pkg::nbload_tag_t sb_free_tag,
  output logic                 load_issue,
  output dec_pkg::reg_addr_t   load_rd,
  input  dec_pkg::xlen_t       x_result,
  output logic                 wen_r,
  output dec_pkg::reg_addr_t   waddr_r,
  output dec_pkg::xlen_t       wdata_r,
  output logic                 decode_valid,
  output dec_pkg::alu_pkt_t    alu_pkt,
  output dec_pkg::lsu_pkt_t    lsu_pkt,
  output dec_pkg::xlen_t       immed,
  output dec_pkg::xlen_t       rs1_data,
  output dec_pkg::xlen_t       rs2_data,
  output dec_pkg::pc_t         pc_d,
  output logic                 wb_valid,
  output logic                 wb_illegal,
  output dec_pkg::xlen_t       wb_instr,
  output dec_pkg::pc_t         wb_pc
);

  dec_pkg::xlen_t      instr;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                legal, is_load, use_imm, is_lui, rs1_used, rs2_used;
  dec_pkg::alu_op_e    alu_op;
  dec_pkg::xlen_t      imm, i_imm, u_imm;
  dec_pkg::reg_addr_t  rd_d;
  logic                haz_x, haz_r, stall;
  logic                x_vld_q, x_wen_q, x_ill_q, r_vld_q, r_wen_q, r_ill_q;
  dec_pkg::reg_addr_t  x_rd_q, r_rd_q;
  dec_pkg::xlen_t      x_instr_q, r_instr_q, r_data_q;
  dec_pkg::pc_t        x_pc_q, r_pc_q;

  function automatic dec_pkg::alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? dec_pkg::ALU_SUB : dec_pkg::ALU_ADD;
      3'b001:  return dec_pkg::ALU_SLL;
      3'b010:  return dec_pkg::ALU_SLT;
      3'b011:  return dec_pkg::ALU_SLTU;
      3'b100:  return dec_pkg::ALU_XOR;
      3'b101:  return alt ? dec_pkg::ALU_SRA : dec_pkg::ALU_SRL;
      3'b110:  return dec_pkg::ALU_OR;
      default: return dec_pkg::ALU_AND;
    endcase
  endfunction

  // ****************************************
  // opcode / funct decode
  // ****************************************
  assign instr  = ib_pkt.instr;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign i_imm  = {{20{instr[31]}}, instr[31:20]};  // sign extended
  assign u_imm  = {instr[31:12], 12'h000};

  always_comb begin
    legal = 1'b0; is_load = 1'b0; use_imm = 1'b0; is_lui = 1'b0;
    rs1_used = 1'b0; rs2_used = 1'b0;
    alu_op = dec_pkg::ALU_ADD;
    imm    = '0;
    case (instr[6:0])
      dec_pkg::OPC_OP: begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        alu_op   = alu_from_f3(funct3, funct7[5]);
        legal    = (funct7 == 7'h00) ||
                   (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      dec_pkg::OPC_OP_IMM: begin
        rs1_used = 1'b1;
        use_imm  = 1'b1;
        imm      = i_imm;
        alu_op   = alu_from_f3(funct3, (funct3 == 3'b101) & funct7[5]);  // no subi
        case (funct3)
          3'b001:  legal = (funct7 == 7'h00);                       // slli
          3'b101:  legal = (funct7 == 7'h00) || (funct7 == 7'h20);  // srli / srai
          default: legal = 1'b1;
        endcase
      end
      dec_pkg::OPC_LUI: begin
        legal   = 1'b1;
        use_imm = 1'b1;
        is_lui  = 1'b1;  // rs1 field belongs to the immediate
        imm     = u_imm;
      end
      dec_pkg::OPC_LOAD: begin
        rs1_used = 1'b1;
        is_load  = 1'b1;
        imm      = i_imm;
        legal    = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
      end
      default: legal = 1'b0;  // anything else traps
    endcase
  end

  // unused fields read as x0 so they never hazard
  assign rs1_addr = (legal & rs1_used) ? instr[19:15] : '0;
  assign rs2_addr = (legal & rs2_used) ? instr[24:20] : '0;
  assign rd_d     = legal ? instr[11:7] : '0;

  // ****************************************
  // interlock
  // ****************************************
  // x/r rd is never x0 when its wen is set
  assign haz_x = x_wen_q & (x_rd_q == rs1_addr || x_rd_q == rs2_addr || x_rd_q == rd_d);
  assign haz_r = r_wen_q & (r_rd_q == rs1_addr || r_rd_q == rs2_addr || r_rd_q == rd_d);
  assign stall = haz_x | haz_r | sb_pending_hit | (is_load & legal & ~sb_tag_free);

  assign decode_take  = ib_pkt.valid & ~stall;
  assign decode_valid = decode_take & legal;  // illegal insns leave silently
  assign load_issue   = decode_valid & is_load;
  assign load_rd      = rd_d;                  // also the waw check for the sb

  always_comb begin
    alu_pkt.valid   = decode_valid & ~is_load;
    alu_pkt.op      = alu_op;
    alu_pkt.use_imm = use_imm;
    alu_pkt.lui     = is_lui;
    lsu_pkt.valid   = load_issue;
    lsu_pkt.tag     = sb_free_tag;   // lowest free slot
    lsu_pkt.offset  = instr[31:20];
  end

  assign immed    = imm;
  assign rs1_data = gpr_rs1;
  assign rs2_data = gpr_rs2;
  assign pc_d     = ib_pkt.pc;

  // ****************************************
  // X and R stages
  // ****************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_vld_q <= 1'b0;
      x_wen_q <= 1'b0;
      r_vld_q <= 1'b0;
      r_wen_q <= 1'b0;
    end else begin
      x_vld_q <= decode_take;                             // bubble on stall
      x_wen_q <= decode_valid & ~is_load & (rd_d != '0);  // x0 never written
      r_vld_q <= x_vld_q;
      r_wen_q <= x_wen_q;
    end
  end

  always_ff @(posedge clk) begin
    if (decode_take) begin
      x_rd_q    <= rd_d;
      x_instr_q <= instr;
      x_pc_q    <= ib_pkt.pc;
      x_ill_q   <= ~legal;
    end
    r_rd_q    <= x_rd_q;
    r_data_q  <= x_result;  // exec result sampled at end of X
    r_instr_q <= x_instr_q;
    r_pc_q    <= x_pc_q;
    r_ill_q   <= x_ill_q;
  end

  // gpr port 0 at R
  assign wen_r   = r_wen_q;
  assign waddr_r = r_rd_q;
  assign wdata_r = r_data_q;

  // into the WB register of the trace block
  assign wb_valid   = r_vld_q;
  assign wb_illegal = r_ill_q;
  assign wb_instr   = r_instr_q;
  assign wb_pc      = r_pc_q;

endmodule

/* rtl/dec_nbload_sb.sv */
// Non-blocking load scoreboard
// Tracks outstanding loads by tag with their destination register, flags
// decode hazards against them and turns each return into a GPR write.

`timescale 1ns/1ps

module dec_nbload_sb (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dec_pkg::reg_addr_t   rs1_addr,
  input  dec_pkg::reg_addr_t   rs2_addr,
  input  dec_pkg::reg_addr_t   load_rd,
  input  logic                 load_issue,
  output logic                 sb_pending_hit,
  output logic                 sb_tag_free,
  output dec_pkg::nbload_tag_t sb_free_tag,
  input  dec_pkg::nbload_ret_t nbload_ret,
  output logic                 nb_wen,
  output dec_pkg::reg_addr_t   nb_waddr,
  output dec_pkg::xlen_t       nb_wdata
);

  logic [dec_pkg::NBLOAD_DEPTH-1:0] pend_q;             // slot busy
  dec_pkg::reg_addr_t               rd_q [dec_pkg::NBLOAD_DEPTH];  // slot dest

  // ****************************************
  // tag allocation and hazard
  // ****************************************
  assign sb_tag_free = ~&pend_q;

  always_comb begin
    sb_free_tag = '0;
    for (int i = dec_pkg::NBLOAD_DEPTH - 1; i >= 0; i--) begin
      if (!pend_q[i]) sb_free_tag = dec_pkg::nbload_tag_t'(i);  // last hit is lowest
    end
  end

  always_comb begin
    sb_pending_hit = 1'b0;
    for (int i = 0; i < dec_pkg::NBLOAD_DEPTH; i++) begin
      if (pend_q[i] && rd_q[i] != '0 &&
          (rd_q[i] == rs1_addr || rd_q[i] == rs2_addr || rd_q[i] == load_rd)) begin
        sb_pending_hit = 1'b1;  // raw or waw on an open load
      end
    end
  end

  // return writes port 1, skipped for x0 or a stray tag
  assign nb_wen   = nbload_ret.valid & pend_q[nbload_ret.tag] & (rd_q[nbload_ret.tag] != '0);
  assign nb_waddr = rd_q[nbload_ret.tag];
  assign nb_wdata = nbload_ret.data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pend_q <= '0;
    end else begin
      if (nbload_ret.valid) pend_q[nbload_ret.tag] <= 1'b0;
      if (load_issue) pend_q[sb_free_tag] <= 1'b1;  // free slot, never the returning one
    end
  end

  always_ff @(posedge clk) begin
    if (load_issue) rd_q[sb_free_tag] <= load_rd;
  end

endmodule

/* rtl/dec_gpr.sv */
// General purpose register file
// x1..x31 with two combinational read ports and two write ports, one for
// R-stage results and one for non-blocking load returns. x0 reads zero.

`timescale 1ns/1ps

module dec_gpr (
  input  logic               clk,
  input  logic               rst_n,
  input  dec_pkg::reg_addr_t raddr0,
  input  dec_pkg::reg_addr_t raddr1,
  output dec_pkg::xlen_t     rd0,
  output dec_pkg::xlen_t     rd1,
  input  logic               wen0,
  input  logic               wen1,
  input  dec_pkg::reg_addr_t waddr0,
  input  dec_pkg::reg_addr_t waddr1,
  input  dec_pkg::xlen_t     wd0,
  input  dec_pkg::xlen_t     wd1
);

  dec_pkg::xlen_t regs_q [1:31];  // no storage for x0

  // ****************************************
  // write ports
  // ****************************************
  // interlock keeps the two ports on different registers
  always_ff @(posedge clk) begin
    for (int i = 1; i < 32; i++) begin
      if (!rst_n) begin
        regs_q[i] <= '0;
      end else if (wen0 && waddr0 == dec_pkg::reg_addr_t'(i)) begin
        regs_q[i] <= wd0;  // alu result
      end else if (wen1 && waddr1 == dec_pkg::reg_addr_t'(i)) begin
        regs_q[i] <= wd1;  // load return
      end
    end
  end

  // ****************************************
  // read ports
  // ****************************************
  // no bypass from this cycle's writes
  assign rd0 = (raddr0 == '0) ? '0 : regs_q[raddr0];
  assign rd1 = (raddr1 == '0) ? '0 : regs_q[raddr1];

endmodule

/* rtl/dec_trace.sv */
// WB trace port
// Registers the insn leaving R into the trace packet, with exception,
// cause and tval filled in for illegal instructions.

`timescale 1ns/1ps

module dec_trace (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wb_valid,
  input  logic                wb_illegal,
  input  dec_pkg::xlen_t      wb_instr,
  input  dec_pkg::pc_t        wb_pc,
  output dec_pkg::trace_pkt_t trace
);

  logic exc;

  assign exc = wb_valid & wb_illegal;  // only cause handled here

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      trace.valid     <= 1'b0;
      trace.exception <= 1'b0;
    end else begin
      trace.valid     <= wb_valid;
      trace.exception <= exc;
      trace.insn      <= wb_instr;
      trace.address   <= {wb_pc, 1'b0};               // byte address
      trace.ecause    <= exc ? dec_pkg::EXC_ILLEGAL_INSN : 5'd0;
      trace.tval      <= exc ? wb_instr : '0;         // faulting encoding
    end
  end

endmodule

/* rtl/dec_top.sv */
// Decode unit top
// Instruction buffer, decoder with interlock, load scoreboard, register
// file and trace port connected together.

`timescale 1ns/1ps

module dec_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dec_pkg::fetch_pkt_t  fetch,
  output logic                 fetch_ready,
  input  dec_pkg::xlen_t       x_result,
  input  dec_pkg::nbload_ret_t nbload_ret,
  output logic                 decode_valid,
  output dec_pkg::alu_pkt_t    alu_pkt,
  output dec_pkg::lsu_pkt_t    lsu_pkt,
  output dec_pkg::xlen_t       immed,
  output dec_pkg::xlen_t       rs1_data,
  output dec_pkg::xlen_t       rs2_data,
  output dec_pkg::pc_t         pc_d,
  output dec_pkg::trace_pkt_t  trace
);

  dec_pkg::fetch_pkt_t  ib_pkt;
  logic                 decode_take;
  dec_pkg::reg_addr_t   rs1_addr, rs2_addr, load_rd;
  dec_pkg::xlen_t       gpr_rs1, gpr_rs2;
  logic                 sb_pending_hit, sb_tag_free, load_issue;
  dec_pkg::nbload_tag_t sb_free_tag;
  logic                 wen_r, nb_wen;                // gpr write enables
  dec_pkg::reg_addr_t   waddr_r, nb_waddr;
  dec_pkg::xlen_t       wdata_r, nb_wdata;
  logic                 wb_valid, wb_illegal;
  dec_pkg::xlen_t       wb_instr;
  dec_pkg::pc_t         wb_pc;

  dec_ib u_ib (.*);

  dec_decode u_decode (.*);

  dec_nbload_sb u_nbload_sb (.*);

  dec_gpr u_gpr (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr0 (rs1_addr),
    .raddr1 (rs2_addr),
    .rd0    (gpr_rs1),
    .rd1    (gpr_rs2),
    .wen0   (wen_r),     // R stage
    .waddr0 (waddr_r),
    .wd0    (wdata_r),
    .wen1   (nb_wen),    // load return
    .waddr1 (nb_waddr),
    .wd1    (nb_wdata)
  );

  dec_trace u_trace (.*);

endmodule

/* tests/dec_tests.svh */
// Decode unit test table
// One row per instruction in program order, with the encoding, the expected
// immediate, decode class and ALU op, and for loads the return delay and data.

typedef enum logic [1:0] {K_ALU, K_LOAD, K_ILL} kind_e;

typedef struct packed {
  dec_pkg::xlen_t   instr;
  logic [31:0]      pc;      // byte address
  dec_pkg::xlen_t   imm;     // expected immed
  kind_e            kind;
  dec_pkg::alu_op_e op;
  logic [7:0]       delay;   // base load return delay, cycles
  dec_pkg::xlen_t   data;    // load return data
} row_t;

localparam int MAX_ROWS = 32;
localparam logic [6:0] OPI = dec_pkg::OPC_OP_IMM;
localparam logic [6:0] LD  = dec_pkg::OPC_LOAD;

row_t  rows [MAX_ROWS];
string names [MAX_ROWS];
int    num_rows = 0;

// ****************************************
// RV32I encoders
// ****************************************
function automatic dec_pkg::xlen_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic dec_pkg::xlen_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic dec_pkg::xlen_t enc_u(input logic [19:0] imm, input logic [4:0] rd);
  return {imm, rd, 7'b0110111};
endfunction

task automatic add_row(input string name, input dec_pkg::xlen_t instr, input dec_pkg::xlen_t imm,
                       input kind_e kind, input dec_pkg::alu_op_e op, input int delay,
                       input dec_pkg::xlen_t data);
  rows[num_rows].instr = instr;
  rows[num_rows].pc    = 32'h100 + 32'(4 * num_rows);  // sequential program
  rows[num_rows].imm   = imm;
  rows[num_rows].kind  = kind;
  rows[num_rows].op    = op;
  rows[num_rows].delay = delay[7:0];
  rows[num_rows].data  = data;
  names[num_rows]      = name;
  num_rows++;
endtask

task automatic add_alu(input string name, input dec_pkg::xlen_t instr, input dec_pkg::xlen_t imm,
                       input dec_pkg::alu_op_e op);
  add_row(name, instr, imm, K_ALU, op, 0, '0);
endtask

task automatic add_load(input string name, input dec_pkg::xlen_t instr,
                        input dec_pkg::xlen_t imm, input int delay, input dec_pkg::xlen_t data);
  add_row(name, instr, imm, K_LOAD, dec_pkg::ALU_ADD, delay, data);
endtask

task automatic add_ill(input string name, input dec_pkg::xlen_t instr);
  add_row(name, instr, '0, K_ILL, dec_pkg::ALU_ADD, 0, '0);
endtask

task automatic build_table();
  add_alu("addi_x1", enc_i(12'h005, 0, 3'b000, 1, OPI), 32'h0000_0005, dec_pkg::ALU_ADD);
  add_alu("addi_x2", enc_i(12'hffd, 1, 3'b000, 2, OPI), 32'hffff_fffd, dec_pkg::ALU_ADD);
  add_alu("add_x3", enc_r(7'h00, 2, 1, 3'b000, 3), '0, dec_pkg::ALU_ADD);
  add_alu("sub_x4", enc_r(7'h20, 3, 2, 3'b000, 4), '0, dec_pkg::ALU_SUB);
  add_alu("lui_x5", enc_u(20'habcde, 5), 32'habcd_e000, dec_pkg::ALU_ADD);
  add_alu("xori_x6", enc_i(12'h7f0, 5, 3'b100, 6, OPI), 32'h0000_07f0, dec_pkg::ALU_XOR);
  add_ill("mret", 32'h3020_0073);                       // system opcode
  add_load("lw_x7", enc_i(12'h008, 1, 3'b010, 7, LD), 32'h0000_0008, 12, 32'h1111_2222);
  add_load("lw_x8", enc_i(12'hffc, 2, 3'b010, 8, LD), 32'hffff_fffc, 1, 32'h3333_4444);
  add_alu("add_x9", enc_r(7'h00, 3, 8, 3'b000, 9), '0, dec_pkg::ALU_ADD);   // waits on x8
  add_alu("or_x10", enc_r(7'h00, 0, 7, 3'b110, 10), '0, dec_pkg::ALU_OR);   // waits on x7
  add_alu("addi_x0", enc_i(12'h009, 1, 3'b000, 0, OPI), 32'h0000_0009, dec_pkg::ALU_ADD);
  add_alu("add_x11", enc_r(7'h00, 1, 0, 3'b000, 11), '0, dec_pkg::ALU_ADD);  // x0 reads 0
  add_ill("mul_x12", enc_r(7'h01, 2, 1, 3'b000, 12));  // M extension not decoded
  add_alu("slt_x12", enc_r(7'h00, 1, 4, 3'b010, 12), '0, dec_pkg::ALU_SLT);
  add_alu("sltu_x13", enc_r(7'h00, 1, 4, 3'b011, 13), '0, dec_pkg::ALU_SLTU);
  add_alu("srai_x14", enc_i(12'h401, 4, 3'b101, 14, OPI), 32'h0000_0401, dec_pkg::ALU_SRA);
  add_alu("sll_x15", enc_r(7'h00, 2, 1, 3'b001, 15), '0, dec_pkg::ALU_SLL);
  add_alu("srl_x16", enc_r(7'h00, 2, 4, 3'b101, 16), '0, dec_pkg::ALU_SRL);
  add_alu("and_x17", enc_r(7'h00, 9, 10, 3'b111, 17), '0, dec_pkg::ALU_AND);
  add_load("lw_x18", enc_i(12'h000, 17, 3'b010, 18, LD), '0, 6, 32'hdead_beef);
  add_load("lhu_x19", enc_i(12'h002, 0, 3'b101, 19, LD), 32'h0000_0002, 1, 32'h0000_8001);
  add_alu("add_x20", enc_r(7'h00, 19, 18, 3'b000, 20), '0, dec_pkg::ALU_ADD);
  add_ill("opcode_7f", 32'hffff_ffff);
  add_alu("sra_x21", enc_r(7'h20, 1, 20, 3'b101, 21), '0, dec_pkg::ALU_SRA);
endtask

/* tests/tb_dec_top.sv */
// Decode unit testbench
// Offers the test table to fetch with random gaps, models execute, the GPR
// and out-of-order load returns, and checks decode and trace per instruction.

`timescale 1ns/1ps

module tb_dec_top;

  localparam logic [31:0] SEED = 32'hc669_e6ed;

  typedef struct packed {
    logic               valid;
    dec_pkg::reg_addr_t rd;
    dec_pkg::xlen_t     data;
  } stage_t;

  logic                 clk;
  logic                 rst_n;
  dec_pkg::fetch_pkt_t  fetch;
  logic                 fetch_ready;
  dec_pkg::xlen_t       x_result;
  dec_pkg::nbload_ret_t nbload_ret;
  logic                 decode_valid;
  dec_pkg::alu_pkt_t    alu_pkt;
  dec_pkg::lsu_pkt_t    lsu_pkt;
  dec_pkg::xlen_t       immed, rs1_data, rs2_data;
  dec_pkg::pc_t         pc_d;
  dec_pkg::trace_pkt_t  trace;

  `include "dec_tests.svh"

  dec_pkg::xlen_t     regs [32];                        // architectural model
  logic [3:0]         ld_busy;                          // model tags in flight
  dec_pkg::reg_addr_t ld_rd [4];
  dec_pkg::xlen_t     ld_data [4];
  int                 ld_due [4];
  stage_t             d_s, x_s, r_s;                    // model pipe D->X->R
  int                 row_errs [MAX_ROWS];
  int                 errors = 0, passed = 0, cycle = 0, limit = 100000;
  int                 f_idx = 0, d_idx = 0, t_idx = 0, gap = 0, max_delay = 0;

  dec_top DUT (.*);

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // cycle count and timeout
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= limit) begin
      $display("timeout: run not finished after %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  // ****************************************
  // checker and reference helpers
  // ****************************************
  task automatic note_failure(input int row);
    errors++;
    if (row >= 0) row_errs[row]++;
  endtask

  task automatic check(input int row, input string what, input logic [31:0] exp,
                       input logic [31:0] act);
    string name;
    name = (row < 0) ? "reset" : names[row];
    if (exp !== act) begin
      $display("error %s %s: expected %h actual %h", name, what, exp, act);
      note_failure(row);
    end
  endtask

  function automatic dec_pkg::xlen_t alu_model(input dec_pkg::alu_op_e op,
                                               input dec_pkg::xlen_t a, input dec_pkg::xlen_t b);
    case (op)
      dec_pkg::ALU_ADD:  return a + b;
      dec_pkg::ALU_SUB:  return a - b;
      dec_pkg::ALU_AND:  return a & b;
      dec_pkg::ALU_OR:   return a | b;
      dec_pkg::ALU_XOR:  return a ^ b;
      dec_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      dec_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      dec_pkg::ALU_SLL:  return a << b[4:0];
      dec_pkg::ALU_SRL:  return a >> b[4:0];
      dec_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      default:           return '0;
    endcase
  endfunction

  function automatic int next_legal(input int start);
    int i;
    i = start;
    while (i < num_rows && rows[i].kind == K_ILL) i++;  // illegal rows never decode
    return i;
  endfunction

  function automatic int free_tag();
    for (int t = 0; t < dec_pkg::NBLOAD_DEPTH; t++) begin
      if (!ld_busy[t]) return t;                       // lowest first
    end
    return -1;
  endfunction

  function automatic logic load_pending(input dec_pkg::reg_addr_t r);
    for (int t = 0; t < dec_pkg::NBLOAD_DEPTH; t++) begin
      if (ld_busy[t] && ld_rd[t] == r && r != '0) return 1'b1;
    end
    return 1'b0;
  endfunction

  // ****************************************
  // per-cycle model, run at negedge
  // ****************************************
  task automatic advance_pipe();
    r_s = x_s;
    x_s = d_s;
    d_s = '0;
    x_result = x_s.data;                               // result during X
    if (r_s.valid && r_s.rd != '0) regs[r_s.rd] = r_s.data;  // write at R
  endtask

  task automatic check_decode();
    row_t               r;
    logic [6:0]         opc;
    dec_pkg::reg_addr_t rs1, rs2;
    dec_pkg::xlen_t     b;
    int                 tag;
    if (!decode_valid) begin
      if (alu_pkt.valid || lsu_pkt.valid) begin
        $display("alu or lsu packet valid raised without decode_valid");
        note_failure(-1);
      end
      return;
    end
    if (d_idx >= num_rows) begin
      $display("decode_valid raised with no legal instruction left");
      note_failure(-1);
      return;
    end
    r   = rows[d_idx];
    opc = r.instr[6:0];
    rs1 = (opc == dec_pkg::OPC_LUI) ? 5'd0 : r.instr[19:15];
    rs2 = (opc == dec_pkg::OPC_OP) ? r.instr[24:20] : 5'd0;
    check(d_idx, "pc", r.pc, {pc_d, 1'b0});
    check(d_idx, "immed", r.imm, immed);
    check(d_idx, "rs1_data", regs[rs1], rs1_data);
    check(d_idx, "rs2_data", regs[rs2], rs2_data);
    if (load_pending(rs1) || load_pending(rs2)) begin
      $display("%s decoded before the load to its source returned", names[d_idx]);
      note_failure(d_idx);
    end
    if (r.kind == K_ALU) begin
      check(d_idx, "alu valid", 1, alu_pkt.valid);
      check(d_idx, "lsu valid", 0, lsu_pkt.valid);
      check(d_idx, "alu op", 32'(r.op), 32'(alu_pkt.op));
      check(d_idx, "use_imm", opc != dec_pkg::OPC_OP, alu_pkt.use_imm);
      check(d_idx, "lui", opc == dec_pkg::OPC_LUI, alu_pkt.lui);
      b = (opc == dec_pkg::OPC_OP) ? regs[rs2] : r.imm;
      d_s.valid = 1'b1;
      d_s.rd    = r.instr[11:7];
      d_s.data  = alu_model(r.op, regs[rs1], b);  // rs1 reads x0 for lui
    end else begin
      tag = free_tag();
      check(d_idx, "alu valid", 0, alu_pkt.valid);
      check(d_idx, "lsu valid", 1, lsu_pkt.valid);
      check(d_idx, "lsu tag", tag, lsu_pkt.tag);
      check(d_idx, "lsu offset", r.imm[11:0], lsu_pkt.offset);
      if (tag >= 0) begin
        ld_busy[tag] = 1'b1;
        ld_rd[tag]   = r.instr[11:7];
        ld_data[tag] = r.data;
        ld_due[tag]  = cycle + r.delay + ($urandom % 4);  // random extra latency
      end
    end
    d_idx = next_legal(d_idx + 1);
  endtask

  task automatic drive_load_return();
    nbload_ret = '0;
    for (int t = 0; t < dec_pkg::NBLOAD_DEPTH; t++) begin
      if (ld_busy[t] && ld_due[t] <= cycle && !nbload_ret.valid) begin
        nbload_ret.valid = 1'b1;
        nbload_ret.tag   = t[1:0];
        nbload_ret.data  = ld_data[t];
        if (ld_rd[t] != '0) regs[ld_rd[t]] = ld_data[t];
        ld_busy[t] = 1'b0;
      end
    end
  endtask

  task automatic check_trace();
    row_t r;
    logic ill;
    if (!trace.valid) return;
    if (t_idx >= num_rows) begin
      $display("trace entry seen after the last instruction");
      note_failure(-1);
      return;
    end
    r   = rows[t_idx];
    ill = (r.kind == K_ILL);
    check(t_idx, "trace insn", r.instr, trace.insn);
    check(t_idx, "trace address", r.pc, trace.address);
    check(t_idx, "trace exception", ill, trace.exception);
    check(t_idx, "trace ecause", ill ? 32'd2 : 32'd0, trace.ecause);
    check(t_idx, "trace tval", ill ? r.instr : 32'd0, trace.tval);
    if (row_errs[t_idx] == 0) begin
      $display("test %s: ok", names[t_idx]);
      passed++;
    end else begin
      $display("test %s: %0d mismatches", names[t_idx], row_errs[t_idx]);
    end
    t_idx++;
  endtask

  task automatic drive_fetch();
    if (f_idx < num_rows && gap == 0 && fetch_ready) begin
      fetch.valid = 1'b1;                              // accepted at next edge
      fetch.instr = rows[f_idx].instr;
      fetch.pc    = rows[f_idx].pc[31:1];
      f_idx++;
      gap = $urandom % 3;
    end else begin
      fetch.valid = 1'b0;
      if (gap > 0) gap--;
    end
  endtask

  task automatic step();
    advance_pipe();
    check_decode();
    check_trace();
    drive_load_return();
    drive_fetch();
  endtask

  // ****************************************
  // main sequence
  // ****************************************
  initial begin
    void'($urandom(SEED));
    rst_n      = 1'b0;
    fetch      = '0;
    x_result   = '0;
    nbload_ret = '0;
    d_s        = '0;
    x_s        = '0;
    r_s        = '0;
    ld_busy    = '0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < MAX_ROWS; i++) row_errs[i] = 0;
    build_table();
    for (int i = 0; i < num_rows; i++) begin
      if (rows[i].delay > max_delay) max_delay = rows[i].delay;
    end
    limit = num_rows * (max_delay + 3 + 4) + 50;  // worst load wait per row
    d_idx = next_legal(0);
    repeat (2) begin
      @(negedge clk);
      check(-1, "fetch_ready", 0, fetch_ready);
      check(-1, "decode_valid", 0, decode_valid);
      check(-1, "trace valid", 0, trace.valid);
    end
    rst_n = 1'b1;
    @(negedge clk);
    check(-1, "decode_valid after reset", 0, decode_valid);
    check(-1, "trace valid after reset", 0, trace.valid);
    if (errors == 0) begin
      $display("test reset: ok");
      passed++;
    end else begin
      $display("test reset: %0d mismatches", errors);
    end
    step();
    while (t_idx < num_rows || ld_busy != '0) begin
      @(negedge clk);
      step();
    end
    if (d_idx != num_rows) begin
      $display("not every legal instruction was decoded");
      note_failure(-1);
    end
    $display("tests %0d, passed %0d, errors %0d", num_rows + 1, passed, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+tests
rtl/dec_pkg.sv
rtl/dec_ib.sv
rtl/dec_decode.sv
rtl/dec_nbload_sb.sv
rtl/dec_gpr.sv
rtl/dec_trace.sv
rtl/dec_top.sv
tests/tb_dec_top.sv

/* Bender.yml */
package:
  name: dec_unit

sources:
  - rtl/dec_pkg.sv
  - rtl/dec_ib.sv
  - rtl/dec_decode.sv
  - rtl/dec_nbload_sb.sv
  - rtl/dec_gpr.sv
  - rtl/dec_trace.sv
  - rtl/dec_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dec_top.sv
